//--- include/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// router ports: local, west, north, east, south
`define NOC_PORTS 5

// mesh coordinates, x in upper half of id, y in lower half
`define NOC_COORD_W 2
`define NOC_ID_W (2 * `NOC_COORD_W)

// packet plane
`define NOC_PAYLOAD_W 10
`define NOC_PKT_FIFO_DEPTH 4

// circuit plane
`define NOC_CDATA_W 8

// node (0,0) unless overridden at the top
`define NOC_MY_ID_DEFAULT 4'h0

`endif

//--- verilog/noc_packet_pkg.sv
`default_nettype none

`include "noc_params.svh"

package noc_packet_pkg;

  // port numbering shared by routing, arbitration and crossbar
  typedef logic [2:0] port_idx_t;

  localparam port_idx_t PORT_LOCAL = 3'd0;
  localparam port_idx_t PORT_WEST  = 3'd1;
  localparam port_idx_t PORT_NORTH = 3'd2;
  localparam port_idx_t PORT_EAST  = 3'd3;
  localparam port_idx_t PORT_SOUTH = 3'd4;

  // one bit per port
  typedef logic [`NOC_PORTS-1:0] port_vec_t;

  // x in upper bits, y in lower bits
  typedef logic [`NOC_ID_W-1:0] node_id_t;

  typedef logic [`NOC_PAYLOAD_W-1:0] payload_t;

  // setup and release also reconfigure the circuit crossbar
  typedef enum logic [1:0] {
    PKT_DATA    = 2'd0,
    PKT_SETUP   = 2'd1,
    PKT_RELEASE = 2'd2
  } pkt_kind_t;

  // single-flit packet, 16 bits
  typedef struct packed {
    node_id_t  dest;
    pkt_kind_t kind;
    payload_t  payload;
  } flit_t;

  typedef struct packed {
    logic  valid;
    flit_t flit;
  } pkt_link_t;

endpackage

`default_nettype wire

//--- verilog/noc_circuit_pkg.sv
`default_nettype none

`include "noc_params.svh"

package noc_circuit_pkg;

  import noc_packet_pkg::*;

  typedef logic [`NOC_CDATA_W-1:0] cdata_t;

  // data qualified by strobe
  typedef struct packed {
    logic   strobe;
    cdata_t data;
  } circ_link_t;

  // one per output, raised in the cycle a flit is granted
  typedef struct packed {
    logic      grant;
    port_idx_t src;
    pkt_kind_t kind;
  } circ_event_t;

endpackage

`default_nettype wire

//--- verilog/packet_input_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module packet_input_port
  import noc_packet_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  node_id_t  my_id,
  input  pkt_link_t in_link,
  output logic      full,
  input  logic      grant,
  output flit_t     head,
  output logic      head_valid,
  output port_vec_t route
);

  localparam int PTR_W = $clog2(`NOC_PKT_FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`NOC_PKT_FIFO_DEPTH - 1);

  flit_t            mem [`NOC_PKT_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  logic [`NOC_COORD_W-1:0] dest_x;
  logic [`NOC_COORD_W-1:0] dest_y;
  logic [`NOC_COORD_W-1:0] my_x;
  logic [`NOC_COORD_W-1:0] my_y;

  assign full       = (count == (PTR_W + 1)'(`NOC_PKT_FIFO_DEPTH));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  // a pop in the same cycle frees the slot even when full
  assign push = in_link.valid && (!full || grant);
  assign pop  = grant && head_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage only
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_link.flit;
    end
  end

  // xy order, x resolved first
  assign dest_x = head.dest[`NOC_ID_W-1 -: `NOC_COORD_W];
  assign dest_y = head.dest[`NOC_COORD_W-1:0];
  assign my_x   = my_id[`NOC_ID_W-1 -: `NOC_COORD_W];
  assign my_y   = my_id[`NOC_COORD_W-1:0];

  always_comb begin
    route = '0;
    if (dest_x > my_x) begin
      route[PORT_EAST] = 1'b1;
    end else if (dest_x < my_x) begin
      route[PORT_WEST] = 1'b1;
    end else if (dest_y > my_y) begin
      route[PORT_NORTH] = 1'b1;
    end else if (dest_y < my_y) begin
      route[PORT_SOUTH] = 1'b1;
    end else begin
      // arrived
      route[PORT_LOCAL] = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/packet_output_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module packet_output_port
  import noc_packet_pkg::*, noc_circuit_pkg::*;
#(
  parameter port_idx_t port = PORT_LOCAL
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  flit_t     [`NOC_PORTS-1:0]    heads,
  input  port_vec_t                     head_valids,
  input  port_vec_t [`NOC_PORTS-1:0]    routes,
  input  logic                          full_in,
  output port_vec_t                     grants,
  output pkt_link_t                     out_link,
  output circ_event_t                   grant_event
);

  port_vec_t req;
  port_idx_t ptr;
  port_idx_t sel;
  logic      hit;
  logic      go;
  logic      valid_q;
  flit_t     flit_q;

  // index base+offs, wrapped over the port count
  function automatic port_idx_t wrap_idx(input port_idx_t base, input int offs);
    int sum;
    sum = int'(base) + offs;
    if (sum >= `NOC_PORTS) begin
      sum = sum - `NOC_PORTS;
    end
    return port_idx_t'(sum);
  endfunction

  // heads that want this output
  always_comb begin
    for (int i = 0; i < `NOC_PORTS; i++) begin
      req[i] = head_valids[i] && routes[i][port];
    end
  end

  // rotating priority, search starts at ptr
  always_comb begin
    sel = ptr;
    hit = 1'b0;
    for (int k = 0; k < `NOC_PORTS; k++) begin
      if (!hit && req[wrap_idx(ptr, k)]) begin
        hit = 1'b1;
        sel = wrap_idx(ptr, k);
      end
    end
  end

  // downstream full blocks the grant, flit stays queued
  assign go     = hit && !full_in;
  assign grants = go ? (port_vec_t'(1) << sel) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      ptr     <= PORT_LOCAL;
    end else begin
      valid_q <= go;
      if (go) begin
        // winner gets lowest priority next time
        ptr <= wrap_idx(sel, 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      flit_q <= heads[sel];
    end
  end

  assign out_link = '{valid: valid_q, flit: flit_q};

  // crossbar writes its connection on this same edge
  assign grant_event = '{grant: go, src: sel, kind: heads[sel].kind};

endmodule

`default_nettype wire

//--- verilog/circuit_crossbar.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module circuit_crossbar
  import noc_packet_pkg::*, noc_circuit_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  circ_event_t [`NOC_PORTS-1:0]    events,
  input  circ_link_t  [`NOC_PORTS-1:0]    circ_in,
  input  port_vec_t                       ack_in,
  output circ_link_t  [`NOC_PORTS-1:0]    circ_out,
  output port_vec_t                       ack_out
);

  // connection table, one entry per output
  port_idx_t src_q [`NOC_PORTS];
  port_vec_t active_q;

  port_vec_t strobe_q;
  cdata_t    data_q [`NOC_PORTS];

  for (genvar o = 0; o < `NOC_PORTS; o++) begin : g_out
    logic       releasing;
    circ_link_t sel_in;

    assign releasing = events[o].grant && (events[o].kind == PKT_RELEASE);
    assign sel_in    = circ_in[src_q[o]];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        active_q[o] <= 1'b0;
        src_q[o]    <= PORT_LOCAL;
        strobe_q[o] <= 1'b0;
      end else begin
        if (events[o].grant && (events[o].kind == PKT_SETUP)) begin
          active_q[o] <= 1'b1;
          src_q[o]    <= events[o].src;
        end else if (releasing) begin
          active_q[o] <= 1'b0;
        end
        // nothing passes once the release edge is reached
        strobe_q[o] <= active_q[o] && !releasing && sel_in.strobe;
      end
    end

    // data only moves with its strobe
    always_ff @(posedge clk) begin
      if (active_q[o] && sel_in.strobe) begin
        data_q[o] <= sel_in.data;
      end
    end

    assign circ_out[o] = '{strobe: strobe_q[o], data: data_q[o]};
  end

  // ack back to whichever input feeds the output
  always_comb begin
    ack_out = '0;
    for (int o = 0; o < `NOC_PORTS; o++) begin
      if (active_q[o] && ack_in[o]) begin
        ack_out[src_q[o]] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/noc_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module noc_router
  import noc_packet_pkg::*, noc_circuit_pkg::*;
#(
  parameter node_id_t my_id = `NOC_MY_ID_DEFAULT
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  pkt_link_t  [`NOC_PORTS-1:0]    pkt_in,
  output port_vec_t                      full_out,
  output pkt_link_t  [`NOC_PORTS-1:0]    pkt_out,
  input  port_vec_t                      full_in,
  input  circ_link_t [`NOC_PORTS-1:0]    circ_in,
  output circ_link_t [`NOC_PORTS-1:0]    circ_out,
  input  port_vec_t                      ack_in,
  output port_vec_t                      ack_out
);

  flit_t       [`NOC_PORTS-1:0] heads;
  port_vec_t                    head_valids;
  port_vec_t   [`NOC_PORTS-1:0] routes;
  // indexed [output][input], and transposed for the inputs
  port_vec_t   [`NOC_PORTS-1:0] grants_by_out;
  port_vec_t   [`NOC_PORTS-1:0] grants_to_in;
  circ_event_t [`NOC_PORTS-1:0] events;

  for (genvar i = 0; i < `NOC_PORTS; i++) begin : g_in
    for (genvar o = 0; o < `NOC_PORTS; o++) begin : g_t
      assign grants_to_in[i][o] = grants_by_out[o][i];
    end

    packet_input_port u_in (
      .clk        (clk),
      .rst_n      (rst_n),
      .my_id      (my_id),
      .in_link    (pkt_in[i]),
      .full       (full_out[i]),
      .grant      (|grants_to_in[i]),
      .head       (heads[i]),
      .head_valid (head_valids[i]),
      .route      (routes[i])
    );
  end

  for (genvar o = 0; o < `NOC_PORTS; o++) begin : g_out
    // local sink always accepts
    packet_output_port #(
      .port (port_idx_t'(o))
    ) u_out (
      .clk         (clk),
      .rst_n       (rst_n),
      .heads       (heads),
      .head_valids (head_valids),
      .routes      (routes),
      .full_in     (full_in[o] && (o != int'(PORT_LOCAL))),
      .grants      (grants_by_out[o]),
      .out_link    (pkt_out[o]),
      .grant_event (events[o])
    );
  end

  circuit_crossbar u_xbar (
    .clk      (clk),
    .rst_n    (rst_n),
    .events   (events),
    .circ_in  (circ_in),
    .ack_in   (ack_in),
    .circ_out (circ_out),
    .ack_out  (ack_out)
  );

endmodule

`default_nettype wire

//--- verif/noc_router_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module noc_router_tb
  import noc_packet_pkg::*, noc_circuit_pkg::*;
();

  // node (1,1)
  localparam node_id_t MY_ID = 4'h5;
  // node (2,1), one hop east
  localparam node_id_t EAST_DEST = 4'h9;
  // node (1,3), reached through north
  localparam node_id_t NORTH_DEST = 4'h7;
  // random, hotspot, east hold, setup and release
  localparam int TOTAL_FLITS = 5 * 16 + 5 * 8 + 8 + 2;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_FLITS + 500;

  logic                          clk;
  logic                          rst_n;
  pkt_link_t  [`NOC_PORTS-1:0]   pkt_in;
  port_vec_t                     full_out;
  pkt_link_t  [`NOC_PORTS-1:0]   pkt_out;
  port_vec_t                     full_in;
  circ_link_t [`NOC_PORTS-1:0]   circ_in;
  circ_link_t [`NOC_PORTS-1:0]   circ_out;
  port_vec_t                     ack_in;
  port_vec_t                     ack_out;

  // flits waiting to be sent, and flits in flight per (input, output)
  flit_t       tx_q [`NOC_PORTS][$];
  flit_t       exp_q [`NOC_PORTS][`NOC_PORTS][$];
  port_vec_t   sent_prev;
  int          seq_no [`NOC_PORTS];
  logic [31:0] lcg_state = 32'hb230f678;
  int          cycle_count = 0;
  int          checks_done = 0;
  int          value_errors = 0;
  int          other_errors = 0;

  noc_router #(.my_id(MY_ID)) dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pkt_in   (pkt_in),
    .full_out (full_out),
    .pkt_out  (pkt_out),
    .full_in  (full_in),
    .circ_in  (circ_in),
    .circ_out (circ_out),
    .ack_in   (ack_in),
    .ack_out  (ack_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // xy dimension order, x first
  function automatic port_idx_t expected_port(input node_id_t dest);
    int dx;
    int dy;
    int mx;
    int my;
    dx = int'(dest[`NOC_ID_W-1 -: `NOC_COORD_W]);
    dy = int'(dest[`NOC_COORD_W-1:0]);
    mx = int'(MY_ID[`NOC_ID_W-1 -: `NOC_COORD_W]);
    my = int'(MY_ID[`NOC_COORD_W-1:0]);
    if (dx > mx) return PORT_EAST;
    if (dx < mx) return PORT_WEST;
    if (dy > my) return PORT_NORTH;
    if (dy < my) return PORT_SOUTH;
    return PORT_LOCAL;
  endfunction

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    checks_done++;
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_circ(input string name, input circ_link_t got, input circ_link_t exp);
    checks_done++;
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks_done++;
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // payload holds source port and sequence number
  task automatic queue_flit(input port_idx_t src, input node_id_t dest, input pkt_kind_t kind);
    flit_t f;
    f.dest = dest;
    f.kind = kind;
    f.payload = payload_t'({src, seq_no[src][6:0]});
    seq_no[src]++;
    tx_q[src].push_back(f);
  endtask

  function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < `NOC_PORTS; i++) begin
      n += tx_q[i].size();
      for (int o = 0; o < `NOC_PORTS; o++) n += exp_q[i][o].size();
    end
    return n;
  endfunction

  task automatic wait_drain();
    while (outstanding() != 0) @(posedge clk);
  endtask

  // one strobe on west, then read east two edges later
  task automatic pulse_west(input cdata_t d);
    circ_in[PORT_WEST] <= '{strobe: 1'b1, data: d};
    @(posedge clk);
    circ_in[PORT_WEST] <= '{strobe: 1'b0, data: '0};
    @(posedge clk);
  endtask

  // link sender; skips a cycle after each send since full lags by one edge
  always @(posedge clk) begin : drive_links
    flit_t f;
    for (int i = 0; i < `NOC_PORTS; i++) begin
      if (rst_n && tx_q[i].size() != 0 && !full_out[i] && !sent_prev[i]) begin
        f = tx_q[i].pop_front();
        exp_q[i][expected_port(f.dest)].push_back(f);
        pkt_in[i] <= '{valid: 1'b1, flit: f};
        sent_prev[i] = 1'b1;
      end else begin
        pkt_in[i].valid <= 1'b0;
        sent_prev[i] = 1'b0;
      end
    end
  end

  // scoreboard over all outputs
  always @(posedge clk) begin : check_outputs
    flit_t     exp_f;
    port_idx_t src;
    if (rst_n) begin
      for (int o = 0; o < `NOC_PORTS; o++) begin
        if (pkt_out[o].valid) begin
          src = pkt_out[o].flit.payload[`NOC_PAYLOAD_W-1 -: 3];
          if (src >= `NOC_PORTS || exp_q[src][o].size() == 0) begin
            other_errors++;
            $display("%0t: output %0d sent a flit that no input sent to it: %h",
                     $time, o, pkt_out[o].flit);
          end else begin
            exp_f = exp_q[src][o].pop_front();
            check_flit($sformatf("pkt_out[%0d].flit", o), pkt_out[o].flit, exp_f);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("%0t: run stopped after %0d cycles, %0d flits never arrived",
               $time, cycle_count, outstanding());
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    circ_link_t exp_c;
    cdata_t     d;
    rst_n = 1'b0;
    pkt_in = '0;
    full_in = '0;
    circ_in = '0;
    ack_in = '0;
    sent_prev = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int p = 0; p < `NOC_PORTS; p++) begin
      check_bit($sformatf("pkt_out[%0d].valid", p), pkt_out[p].valid, 1'b0);
      check_bit($sformatf("full_out[%0d]", p), full_out[p], 1'b0);
      check_bit($sformatf("circ_out[%0d].strobe", p), circ_out[p].strobe, 1'b0);
    end

    // random destinations from every input
    for (int n = 0; n < 16; n++) begin
      for (int i = 0; i < `NOC_PORTS; i++) begin
        lcg_state = lcg_next(lcg_state);
        queue_flit(port_idx_t'(i), node_id_t'(lcg_state[31 -: `NOC_ID_W]), PKT_DATA);
      end
    end
    wait_drain();

    // all five inputs into north
    for (int n = 0; n < 8; n++) begin
      for (int i = 0; i < `NOC_PORTS; i++) queue_flit(port_idx_t'(i), NORTH_DEST, PKT_DATA);
    end
    wait_drain();

    // east held full, west fills its fifo
    full_in[PORT_EAST] <= 1'b1;
    for (int n = 0; n < 8; n++) begin
      lcg_state = lcg_next(lcg_state);
      queue_flit(PORT_WEST, node_id_t'({1'b1, lcg_state[30:28]}), PKT_DATA);
    end
    repeat (2) @(posedge clk);
    repeat (30) begin
      @(posedge clk);
      check_bit("pkt_out[east].valid", pkt_out[PORT_EAST].valid, 1'b0);
    end
    check_bit("full_out[west]", full_out[PORT_WEST], 1'b1);
    full_in[PORT_EAST] <= 1'b0;
    wait_drain();

    // circuit west to east
    queue_flit(PORT_WEST, EAST_DEST, PKT_SETUP);
    wait_drain();
    @(posedge clk);
    lcg_state = lcg_next(lcg_state);
    d = cdata_t'(lcg_state[31 -: `NOC_CDATA_W]);
    pulse_west(d);
    exp_c = '{strobe: 1'b1, data: d};
    check_circ("circ_out[east]", circ_out[PORT_EAST], exp_c);
    for (int p = 0; p < `NOC_PORTS; p++) begin
      if (p != int'(PORT_EAST)) begin
        check_bit($sformatf("circ_out[%0d].strobe", p), circ_out[p].strobe, 1'b0);
      end
    end
    ack_in[PORT_EAST] <= 1'b1;
    @(posedge clk);
    for (int p = 0; p < `NOC_PORTS; p++) begin
      check_bit($sformatf("ack_out[%0d]", p), ack_out[p], p == int'(PORT_WEST));
    end
    ack_in <= '0;

    // release, then the path is dead
    queue_flit(PORT_WEST, EAST_DEST, PKT_RELEASE);
    wait_drain();
    @(posedge clk);
    pulse_west(~d);
    check_bit("circ_out[east].strobe", circ_out[PORT_EAST].strobe, 1'b0);
    ack_in[PORT_EAST] <= 1'b1;
    @(posedge clk);
    check_bit("ack_out[west]", ack_out[PORT_WEST], 1'b0);
    ack_in <= '0;
    repeat (2) @(posedge clk);

    $display("%0d checks, %0d value errors, %0d other errors",
             checks_done, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
verilog/noc_packet_pkg.sv
verilog/noc_circuit_pkg.sv
verilog/packet_input_port.sv
verilog/packet_output_port.sv
verilog/circuit_crossbar.sv
verilog/noc_router.sv
verif/noc_router_tb.sv

//--- run.sh
#!/bin/sh
# build and run the router testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module noc_router_tb -f compile.f -o noc_router_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/noc_router_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  exit 1
fi
grep -q "Finished with no errors" "$LOG" || exit 1
exit 0
